/* design/flist_cfg.svh */
`ifndef FLIST_CFG_SVH
`define FLIST_CFG_SVH

// ------------------------------
// ID pool
// ------------------------------

// Bits in one ID
`define ID_WIDTH 4

// IDs managed by the free list, 0 to ID_COUNT-1
`define ID_COUNT 16

// Must hold the value ID_COUNT itself
`define COUNT_WIDTH 5

// Entries in the ID buffer, a power of two
`define FIFO_DEPTH 8

`endif

/* design/flist_types_pkg.sv */
`default_nettype none

`include "flist_cfg.svh"

package flist_types_pkg;

   // Index bits plus one wrap bit
   localparam int FIFO_PTR_WIDTH = $clog2(`FIFO_DEPTH) + 1;

   // One ID as granted or released
   typedef logic [`ID_WIDTH-1:0] id_t;

   // Number of IDs currently free
   typedef logic [`COUNT_WIDTH-1:0] free_count_t;

   // Slot in the free queue
   typedef logic [`ID_WIDTH-1:0] qptr_t;

   // Buffer pointer, top bit tells full from empty
   typedef logic [FIFO_PTR_WIDTH-1:0] fifo_ptr_t;

endpackage

`default_nettype wire

/* design/flist_state_pkg.sv */
`default_nettype none

package flist_state_pkg;

   // Free list, fill sweep then normal service
   typedef enum logic {
      FL_INIT,
      FL_READY
   } flist_state_t;

   // Producer side
   typedef enum logic {
      AC_IDLE,
      AC_WAIT_ACK
   } alloc_state_t;

   // Consumer side
   typedef enum logic [1:0] {
      RC_IDLE,
      RC_POP,
      RC_WAIT_ACK
   } rel_state_t;

endpackage

`default_nettype wire

/* design/free_list.sv */
`timescale 1ns/1ps
`default_nettype none

`include "flist_cfg.svh"

module free_list
   import flist_types_pkg::*;
   import flist_state_pkg::*;
(
   input  wire              SYSTEM_CLOCK,
   input  wire              reset,
   input  wire              alloc_req,
   input  wire              dealloc_req,
   input  wire id_t         dealloc_id,
   output logic             alloc_ack,
   output id_t              alloc_id,
   output logic             dealloc_ack,
   output logic             init_done,
   output free_count_t      free_count
);

   id_t          queue_mem [`ID_COUNT];
   qptr_t        head_ptr;
   qptr_t        tail_ptr;
   flist_state_t state;
   logic         alloc_pend;
   logic         grant;
   logic         take_back;
   logic         wr_en;
   id_t          wr_data;

   // Circular step, ID_COUNT need not be a power of two
   function automatic qptr_t qptr_next(input qptr_t ptr);
      qptr_t nxt;
      if (ptr == qptr_t'(`ID_COUNT - 1))
         nxt = '0;
      else
         nxt = ptr + 1'b1;
      return nxt;
   endfunction

   // ------------------------------
   // Request decode
   // ------------------------------

   // A request seen with nothing free waits in alloc_pend
   assign grant     = (state == FL_READY) && (alloc_req || alloc_pend) && (free_count != '0);
   assign take_back = (state == FL_READY) && dealloc_req;

   // Fill sweep writes each slot with its own index
   assign wr_en   = (state == FL_INIT) || take_back;
   assign wr_data = (state == FL_INIT) ? id_t'(tail_ptr) : dealloc_id;

   always_ff @(posedge SYSTEM_CLOCK)
   begin
      if (wr_en)
         queue_mem[tail_ptr] <= wr_data;
      if (grant)
         alloc_id <= queue_mem[head_ptr];
   end

   // ------------------------------
   // Control
   // ------------------------------
   always_ff @(posedge SYSTEM_CLOCK)
   begin
      if (reset)
      begin
         state       <= FL_INIT;
         head_ptr    <= '0;
         tail_ptr    <= '0;
         free_count  <= '0;
         alloc_pend  <= 1'b0;
         alloc_ack   <= 1'b0;
         dealloc_ack <= 1'b0;
         init_done   <= 1'b0;
      end
      else
      begin
         alloc_ack   <= grant;
         dealloc_ack <= take_back;
         case (state)
            FL_INIT:
            begin
               tail_ptr   <= qptr_next(tail_ptr);
               free_count <= free_count + 1'b1;
               if (tail_ptr == qptr_t'(`ID_COUNT - 1))
               begin
                  state     <= FL_READY;
                  init_done <= 1'b1;
               end
            end
            FL_READY:
            begin
               if (grant)
                  head_ptr <= qptr_next(head_ptr);
               if (take_back)
                  tail_ptr <= qptr_next(tail_ptr);
               if (grant)
                  alloc_pend <= 1'b0;
               else if (alloc_req)
                  alloc_pend <= 1'b1;
               // Grant and release together leave the count alone
               if (grant && !take_back)
                  free_count <= free_count - 1'b1;
               else if (take_back && !grant)
                  free_count <= free_count + 1'b1;
            end
            default:
               state <= FL_INIT;
         endcase
      end
   end

endmodule

`default_nettype wire

/* design/id_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "flist_cfg.svh"

module id_fifo
   import flist_types_pkg::*;
(
   input  wire       SYSTEM_CLOCK,
   input  wire       reset,
   input  wire       push,
   input  wire       pop,
   input  wire id_t  din,
   output id_t       dout,
   output logic      rdy,
   output logic      not_full
);

   localparam int ADDR_W = FIFO_PTR_WIDTH - 1;

   id_t       fifo_mem [`FIFO_DEPTH];
   fifo_ptr_t wr_ptr;
   fifo_ptr_t rd_ptr;
   logic      do_push;
   logic      do_pop;

   // ------------------------------
   // Status
   // ------------------------------

   // Same slot, same lap means empty; same slot, other lap means full
   assign rdy      = (wr_ptr != rd_ptr);
   assign not_full = !((wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]) &&
                       (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]));

   assign do_push = push && not_full;
   assign do_pop  = pop && rdy;

   // Head shows without a pop
   assign dout = fifo_mem[rd_ptr[ADDR_W-1:0]];

   always_ff @(posedge SYSTEM_CLOCK)
   begin
      if (do_push)
         fifo_mem[wr_ptr[ADDR_W-1:0]] <= din;
   end

   always_ff @(posedge SYSTEM_CLOCK)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* design/alloc_client.sv */
`timescale 1ns/1ps
`default_nettype none

module alloc_client
   import flist_types_pkg::*;
   import flist_state_pkg::*;
(
   input  wire       SYSTEM_CLOCK,
   input  wire       reset,
   input  wire       run,
   input  wire       init_done,
   input  wire       not_full,
   input  wire       alloc_ack,
   input  wire id_t  alloc_id,
   output logic      alloc_req,
   output logic      push,
   output id_t       din
);

   alloc_state_t state;
   logic         can_request;

   // not_full lags a push by a cycle, so skip the cycle a push is on the way
   assign can_request = run && init_done && not_full && !push;

   // ------------------------------
   // Request FSM
   // ------------------------------
   always_ff @(posedge SYSTEM_CLOCK)
   begin
      if (reset)
      begin
         state     <= AC_IDLE;
         alloc_req <= 1'b0;
         push      <= 1'b0;
      end
      else
      begin
         alloc_req <= 1'b0;
         push      <= 1'b0;
         case (state)
            AC_IDLE:
               if (can_request)
               begin
                  alloc_req <= 1'b1;
                  state     <= AC_WAIT_ACK;
               end
            AC_WAIT_ACK:
               if (alloc_ack)
               begin
                  push  <= 1'b1;
                  state <= AC_IDLE;
               end
            default:
               state <= AC_IDLE;
         endcase
      end
   end

   // Granted ID goes out with the push
   always_ff @(posedge SYSTEM_CLOCK)
   begin
      if (state == AC_WAIT_ACK && alloc_ack)
         din <= alloc_id;
   end

endmodule

`default_nettype wire

/* design/release_client.sv */
`timescale 1ns/1ps
`default_nettype none

module release_client
   import flist_types_pkg::*;
   import flist_state_pkg::*;
(
   input  wire       SYSTEM_CLOCK,
   input  wire       reset,
   input  wire       hold_release,
   input  wire       rdy,
   input  wire id_t  dout,
   input  wire       dealloc_ack,
   output logic      pop,
   output logic      dealloc_req,
   output id_t       dealloc_id
);

   rel_state_t state;

   // ------------------------------
   // Release FSM
   // ------------------------------
   always_ff @(posedge SYSTEM_CLOCK)
   begin
      if (reset)
      begin
         state       <= RC_IDLE;
         pop         <= 1'b0;
         dealloc_req <= 1'b0;
      end
      else
      begin
         pop         <= 1'b0;
         dealloc_req <= 1'b0;
         case (state)
            // Hold only blocks a new pop
            RC_IDLE:
               if (rdy && !hold_release)
               begin
                  pop   <= 1'b1;
                  state <= RC_POP;
               end
            RC_POP:
            begin
               dealloc_req <= 1'b1;
               state       <= RC_WAIT_ACK;
            end
            RC_WAIT_ACK:
               if (dealloc_ack)
                  state <= RC_IDLE;
            default:
               state <= RC_IDLE;
         endcase
      end
   end

   // Head is still on dout while pop is high
   always_ff @(posedge SYSTEM_CLOCK)
   begin
      if (state == RC_POP)
         dealloc_id <= dout;
   end

endmodule

`default_nettype wire

/* design/id_loop_top.sv */
`timescale 1ns/1ps
`default_nettype none

module id_loop_top
   import flist_types_pkg::*;
(
   input  wire               SYSTEM_CLOCK,
   input  wire               reset,
   input  wire               run,
   input  wire               hold_release,
   output wire               init_done,
   output wire               alloc_valid,
   output wire id_t          alloc_id,
   output wire               release_valid,
   output wire id_t          release_id,
   output wire free_count_t  free_count
);

   wire      alloc_req;
   wire      dealloc_req;
   wire      push;
   wire      pop;
   wire      rdy;
   wire      not_full;
   wire id_t din;
   wire id_t dout;

   // Ack pulses and their IDs double as the observation ports
   free_list free_list_inst (
      .SYSTEM_CLOCK (SYSTEM_CLOCK),
      .reset        (reset),
      .alloc_req    (alloc_req),
      .dealloc_req  (dealloc_req),
      .dealloc_id   (release_id),
      .alloc_ack    (alloc_valid),
      .alloc_id     (alloc_id),
      .dealloc_ack  (release_valid),
      .init_done    (init_done),
      .free_count   (free_count)
   );

   alloc_client alloc_client_inst (
      .SYSTEM_CLOCK (SYSTEM_CLOCK),
      .reset        (reset),
      .run          (run),
      .init_done    (init_done),
      .not_full     (not_full),
      .alloc_ack    (alloc_valid),
      .alloc_id     (alloc_id),
      .alloc_req    (alloc_req),
      .push         (push),
      .din          (din)
   );

   id_fifo id_fifo_inst (
      .SYSTEM_CLOCK (SYSTEM_CLOCK),
      .reset        (reset),
      .push         (push),
      .pop          (pop),
      .din          (din),
      .dout         (dout),
      .rdy          (rdy),
      .not_full     (not_full)
   );

   release_client release_client_inst (
      .SYSTEM_CLOCK (SYSTEM_CLOCK),
      .reset        (reset),
      .hold_release (hold_release),
      .rdy          (rdy),
      .dout         (dout),
      .dealloc_ack  (release_valid),
      .pop          (pop),
      .dealloc_req  (dealloc_req),
      .dealloc_id   (release_id)
   );

endmodule

`default_nettype wire

/* tb/id_loop_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

`include "flist_cfg.svh"

module id_loop_asserts
   import flist_types_pkg::*;
(
   input wire              SYSTEM_CLOCK,
   input wire              reset,
   input wire              alloc_req,
   input wire              alloc_valid,
   input wire              dealloc_req,
   input wire              release_valid,
   input wire free_count_t free_count,
   input wire              push,
   input wire              pop,
   input wire              rdy,
   input wire              not_full,
   input wire              init_done
);

   // ------------------------------
   // Handshake pulses
   // ------------------------------

   // Ack follows next cycle whenever an ID was free at the request
   a_alloc_req_pulse : assert property (@(posedge SYSTEM_CLOCK) disable iff (reset)
      alloc_req |=> !alloc_req && (alloc_valid || $past(free_count) == '0))
      else $error("alloc_req held high or not acked in the next cycle");

   a_dealloc_req_pulse : assert property (@(posedge SYSTEM_CLOCK) disable iff (reset)
      dealloc_req |=> release_valid && !dealloc_req)
      else $error("dealloc_req held high or not acked in the next cycle");

   // ------------------------------
   // Buffer flow control
   // ------------------------------
   a_push_room : assert property (@(posedge SYSTEM_CLOCK) disable iff (reset)
      push |-> not_full)
      else $error("push while the FIFO is full");

   a_pop_data : assert property (@(posedge SYSTEM_CLOCK) disable iff (reset)
      pop |-> rdy)
      else $error("pop while the FIFO is empty");

   // Fill sweep takes one cycle per ID
   a_init_time : assert property (@(posedge SYSTEM_CLOCK)
      $fell(reset) |-> ##[1:`ID_COUNT+1] init_done)
      else $error("init_done late after reset");

endmodule

bind id_loop_top id_loop_asserts id_loop_asserts_inst (
   .SYSTEM_CLOCK  (SYSTEM_CLOCK),
   .reset         (reset),
   .alloc_req     (alloc_req),
   .alloc_valid   (alloc_valid),
   .dealloc_req   (dealloc_req),
   .release_valid (release_valid),
   .free_count    (free_count),
   .push          (push),
   .pop           (pop),
   .rdy           (rdy),
   .not_full      (not_full),
   .init_done     (init_done)
);

`default_nettype wire

/* tb/id_loop_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "flist_cfg.svh"

module id_loop_tb
   import flist_types_pkg::*;
;

   localparam int MAX_PHASES = 32;
   localparam int HOLD_CYCLES = 100;

   logic        SYSTEM_CLOCK;
   logic        reset;
   logic        run;
   logic        hold_release;
   wire         init_done;
   wire         alloc_valid;
   id_t         alloc_id;
   wire         release_valid;
   id_t         release_id;
   free_count_t free_count;

   logic [23:0] phase_mem [MAX_PHASES];
   id_t         outstanding_q[$];
   int          grant_count = 0;
   int          max_outstanding = 0;
   int          watchdog_cycles = 0;
   bit          init_seen = 0;
   string       phase_name = "reset";

   id_loop_top id_loop_top_inst (
      .SYSTEM_CLOCK  (SYSTEM_CLOCK),
      .reset         (reset),
      .run           (run),
      .hold_release  (hold_release),
      .init_done     (init_done),
      .alloc_valid   (alloc_valid),
      .alloc_id      (alloc_id),
      .release_valid (release_valid),
      .release_id    (release_id),
      .free_count    (free_count)
   );

   always #2 SYSTEM_CLOCK = ~SYSTEM_CLOCK;

   // ------------------------------
   // Reporting and compare tasks
   // ------------------------------
   task automatic stop_with_error(input string msg);
      $display("%s", msg);
      $display("Simulation failed");
      $fatal(1, "run stopped at first error");
   endtask

   task automatic check_id(input string name, input id_t expected, input id_t actual);
      if (expected !== actual)
         stop_with_error($sformatf("MISMATCH %s: expected id %0d actual id %0d",
                                   name, expected, actual));
   endtask

   task automatic check_count(input string name, input free_count_t expected,
                              input free_count_t actual);
      if (expected !== actual)
         stop_with_error($sformatf("MISMATCH %s: expected free_count %0d actual %0d",
                                   name, expected, actual));
   endtask

   function automatic string phase_kind(input logic run_f, input logic hold_f);
      if (hold_f)
         return "hold";
      else if (run_f)
         return "stream";
      else
         return "drain";
   endfunction

   // ------------------------------
   // Reference model, sampled mid-cycle
   // ------------------------------
   always @(negedge SYSTEM_CLOCK)
   begin : monitor
      id_t expected_id;
      if (!reset && !init_done && alloc_valid)
         stop_with_error("alloc_valid seen before init_done");
      if (!reset && init_done)
      begin
         if (!init_seen)
         begin
            check_count("init", free_count_t'(`ID_COUNT), free_count);
            init_seen = 1;
         end
         // Free queue starts in order and releases come back in grant order
         if (alloc_valid)
         begin
            expected_id = id_t'(grant_count % `ID_COUNT);
            check_id(phase_name, expected_id, alloc_id);
            outstanding_q.push_back(expected_id);
            grant_count++;
         end
         if (release_valid)
         begin
            if (outstanding_q.size() == 0)
               stop_with_error($sformatf("release in %s with no outstanding ID", phase_name));
            expected_id = outstanding_q.pop_front();
            check_id(phase_name, expected_id, release_id);
         end
         check_count(phase_name, free_count_t'(`ID_COUNT - outstanding_q.size()), free_count);
         if (hold_release && outstanding_q.size() > max_outstanding)
            max_outstanding = outstanding_q.size();
      end
   end

   // Limit follows the grant total from the data file
   initial
   begin : watchdog
      wait (watchdog_cycles > 0);
      repeat (watchdog_cycles) @(posedge SYSTEM_CLOCK);
      $display("Timeout: no progress within %0d cycles", watchdog_cycles);
      $display("Simulation failed");
      $fatal(1, "watchdog expired");
   end

   // ------------------------------
   // Phase sequencer
   // ------------------------------
   initial
   begin : sequencer
      int          idx;
      int          total_grants;
      int          target;
      int          quiet;
      logic [23:0] word;
      SYSTEM_CLOCK = 1'b0;
      reset        = 1'b1;
      run          = 1'b0;
      hold_release = 1'b0;
      total_grants = 0;
      $readmemh("tb/id_loop_testdata.txt", phase_mem);
      for (idx = 0; idx < MAX_PHASES; idx++)
      begin
         if (!$isunknown(phase_mem[idx]))
            total_grants += phase_mem[idx][15:0];
      end
      if ($isunknown(phase_mem[0]))
         stop_with_error("no phases read from tb/id_loop_testdata.txt");
      watchdog_cycles = total_grants * 200 + 1000;

      repeat (16) @(posedge SYSTEM_CLOCK);
      reset <= 1'b0;
      // Requests during the fill sweep must be ignored
      run   <= 1'b1;
      while (!init_done)
         @(posedge SYSTEM_CLOCK);

      for (idx = 0; idx < MAX_PHASES; idx++)
      begin
         word = phase_mem[idx];
         if ($isunknown(word))
            break;
         phase_name = $sformatf("phase %0d (%s)", idx, phase_kind(word[20], word[16]));
         max_outstanding = outstanding_q.size();
         run          <= word[20];
         hold_release <= word[16];
         if (word[15:0] != 0)
         begin
            target = grant_count + word[15:0];
            while (grant_count < target)
               @(posedge SYSTEM_CLOCK);
         end
         else if (word[16])
         begin
            repeat (HOLD_CYCLES) @(posedge SYSTEM_CLOCK);
            // FIFO full plus one ID in the release path at most
            if (max_outstanding > `FIFO_DEPTH + 1)
               stop_with_error($sformatf("%s: %0d IDs outstanding, more than %0d allowed",
                                         phase_name, max_outstanding, `FIFO_DEPTH + 1));
         end
         else
         begin
            quiet = 0;
            while (quiet < 20)
            begin
               @(posedge SYSTEM_CLOCK);
               if (outstanding_q.size() == 0)
                  quiet++;
               else
                  quiet = 0;
            end
            @(negedge SYSTEM_CLOCK);
            check_count(phase_name, free_count_t'(`ID_COUNT), free_count);
         end
         @(posedge SYSTEM_CLOCK);
      end

      run          <= 1'b0;
      hold_release <= 1'b0;
      repeat (4) @(posedge SYSTEM_CLOCK);
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

/* compile.f */
+incdir+design
design/flist_types_pkg.sv
design/flist_state_pkg.sv
design/free_list.sv
design/id_fifo.sv
design/alloc_client.sv
design/release_client.sv
design/id_loop_top.sv
tb/id_loop_asserts.sv
tb/id_loop_tb.sv

/* tb/id_loop_testdata.txt */
// One hex word per phase: run flag, hold_release flag, alloc_valid events to wait for
// Count 0 means a fixed 100 cycle hold when hold is set, else a full drain
1_0_0028
1_1_0000
1_0_0020
0_0_0000
1_0_0010
1_1_0000
0_0_0000
